// File: src/ctr_pkg.sv
`default_nettype none

package ctr_pkg;

    // number of counters in the bank
    localparam int unsigned NUM_CTR = 4;
    // width of each counter
    localparam int unsigned CTR_WIDTH = 16;
    // width of a counter index
    localparam int unsigned IDX_WIDTH = 2;
    // sticky overflow flag in every counter
    localparam bit LATCH_OVF = 1'b1;

    // command opcodes
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_CLEAR = 3'd1,
        OP_LOAD  = 3'd2,
        OP_ADD   = 3'd3,
        OP_SUB   = 3'd4,
        OP_READ  = 3'd5
    } ctr_op_e;

    // command word from the outside world
    typedef struct packed {
        ctr_op_e                op;
        logic [IDX_WIDTH-1:0]   idx;
        // load value or delta, depending on the opcode
        logic [CTR_WIDTH-1:0]   data;
    } ctr_cmd_t;

    // decoded controls, registered in the decode stage
    typedef struct packed {
        // one-hot counter select
        logic [NUM_CTR-1:0]     sel;
        logic                   clear;
        logic                   load;
        logic                   en;
        logic                   down;
        // shared load value and delta
        logic [CTR_WIDTH-1:0]   value;
        logic                   rd;
        logic [IDX_WIDTH-1:0]   rd_idx;
    } ctr_ctrl_t;

    // read response
    typedef struct packed {
        logic [CTR_WIDTH-1:0]   value;
        logic                   overflow;
    } ctr_rsp_t;

endpackage

`default_nettype wire

// File: src/delta_counter.sv
`timescale 1ns/1ps
`default_nettype none

module delta_counter #(
    parameter int unsigned WIDTH          = 4,
    parameter bit          LATCH_OVERFLOW = 1'b0
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    // synchronous clear, highest priority
    input  logic             clear_i,
    // count enable
    input  logic             en_i,
    // load d_i, wins over counting
    input  logic             load_i,
    // count down instead of up
    input  logic             down_i,
    input  logic [WIDTH-1:0] delta_i,
    input  logic [WIDTH-1:0] d_i,
    output logic [WIDTH-1:0] q_o,
    output logic             overflow_o
);

    // one extra bit holds the carry or borrow of the last step
    logic [WIDTH:0] cnt_q;
    logic [WIDTH:0] cnt_d;

    if (LATCH_OVERFLOW) begin : gen_latched_ovf
        logic ovf_q;
        logic ovf_d;

        always_comb begin
            ovf_d = ovf_q;
            if (clear_i || load_i) begin
                ovf_d = 1'b0;
            end else if (en_i && !ovf_q) begin
                // compare against the visible bits only
                if (down_i) begin
                    ovf_d = (delta_i > cnt_q[WIDTH-1:0]);
                end else begin
                    ovf_d = (cnt_q[WIDTH-1:0] > ({WIDTH{1'b1}} - delta_i));
                end
            end
        end

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                ovf_q <= 1'b0;
            end else begin
                ovf_q <= ovf_d;
            end
        end

        assign overflow_o = ovf_q;
    end else begin : gen_transient_ovf
        // carry out of the last step, seen for as long as it sits in the msb
        assign overflow_o = cnt_q[WIDTH];
    end

    // next count: clear, then load, then count
    always_comb begin
        cnt_d = cnt_q;
        if (clear_i) begin
            cnt_d = '0;
        end else if (load_i) begin
            cnt_d = {1'b0, d_i};
        end else if (en_i) begin
            if (down_i) begin
                cnt_d = {1'b0, cnt_q[WIDTH-1:0]} - {1'b0, delta_i};
            end else begin
                cnt_d = {1'b0, cnt_q[WIDTH-1:0]} + {1'b0, delta_i};
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // low bits wrap modulo 2**WIDTH
    assign q_o = cnt_q[WIDTH-1:0];

endmodule

`default_nettype wire

// File: src/ctr_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ctr_cmd_decoder (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                cmd_valid_i,
    input  ctr_pkg::ctr_cmd_t   cmd_i,
    output ctr_pkg::ctr_ctrl_t  ctrl_o
);

    ctr_pkg::ctr_ctrl_t ctrl_d;
    ctr_pkg::ctr_ctrl_t ctrl_q;

    // combinational decode of the incoming command
    always_comb begin
        ctrl_d = '0;
        if (cmd_valid_i) begin
            // index to one-hot select
            ctrl_d.sel    = ctr_pkg::NUM_CTR'(1) << cmd_i.idx;
            ctrl_d.value  = cmd_i.data;
            ctrl_d.rd_idx = cmd_i.idx;
            case (cmd_i.op)
                ctr_pkg::OP_CLEAR: begin
                    ctrl_d.clear = 1'b1;
                end
                ctr_pkg::OP_LOAD: begin
                    ctrl_d.load = 1'b1;
                end
                ctr_pkg::OP_ADD: begin
                    ctrl_d.en = 1'b1;
                end
                ctr_pkg::OP_SUB: begin
                    ctrl_d.en   = 1'b1;
                    ctrl_d.down = 1'b1;
                end
                ctr_pkg::OP_READ: begin
                    ctrl_d.rd = 1'b1;
                end
                default: begin
                    // nop and unused codes leave every control low
                    ctrl_d.sel = '0;
                end
            endcase
        end
    end

    // controls reach bank and readback one cycle after the command
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_d;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// File: src/ctr_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ctr_bank (
    input  logic                                                    clk_i,
    input  logic                                                    rst_ni,
    input  ctr_pkg::ctr_ctrl_t                                      ctrl_i,
    output logic [ctr_pkg::NUM_CTR-1:0][ctr_pkg::CTR_WIDTH-1:0]     values_o,
    output logic [ctr_pkg::NUM_CTR-1:0]                             overflows_o
);

    for (genvar i = 0; i < ctr_pkg::NUM_CTR; i++) begin : gen_ctr
        logic clear;
        logic load;
        logic en;
        logic down;

        // shared controls only reach the selected counter
        assign clear = ctrl_i.clear & ctrl_i.sel[i];
        assign load  = ctrl_i.load  & ctrl_i.sel[i];
        assign en    = ctrl_i.en    & ctrl_i.sel[i];
        assign down  = ctrl_i.down  & ctrl_i.sel[i];

        // value doubles as load data and delta
        delta_counter #(
            .WIDTH          (ctr_pkg::CTR_WIDTH),
            .LATCH_OVERFLOW (ctr_pkg::LATCH_OVF)
        ) i_delta_counter (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .clear_i    (clear),
            .en_i       (en),
            .load_i     (load),
            .down_i     (down),
            .delta_i    (ctrl_i.value),
            .d_i        (ctrl_i.value),
            .q_o        (values_o[i]),
            .overflow_o (overflows_o[i])
        );
    end

endmodule

`default_nettype wire

// File: src/ctr_readback.sv
`timescale 1ns/1ps
`default_nettype none

module ctr_readback (
    input  logic                                                    clk_i,
    input  logic                                                    rst_ni,
    input  ctr_pkg::ctr_ctrl_t                                      ctrl_i,
    input  logic [ctr_pkg::NUM_CTR-1:0][ctr_pkg::CTR_WIDTH-1:0]     values_i,
    input  logic [ctr_pkg::NUM_CTR-1:0]                             overflows_i,
    output ctr_pkg::ctr_rsp_t                                       rsp_o,
    output logic                                                    rsp_valid_o
);

    ctr_pkg::ctr_rsp_t rsp_d;
    ctr_pkg::ctr_rsp_t rsp_q;
    logic              valid_q;

    // ctrl_i is already one cycle behind the command, so the bank
    // outputs here include every earlier update
    always_comb begin
        // hold the last response when there is no read
        rsp_d = rsp_q;
        if (ctrl_i.rd) begin
            rsp_d.value    = values_i[ctrl_i.rd_idx];
            rsp_d.overflow = overflows_i[ctrl_i.rd_idx];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            rsp_q   <= rsp_d;
            // single-cycle pulse per read
            valid_q <= ctrl_i.rd;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = valid_q;

endmodule

`default_nettype wire

// File: src/ctr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ctr_unit (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                cmd_valid_i,
    input  ctr_pkg::ctr_cmd_t   cmd_i,
    output ctr_pkg::ctr_rsp_t   rsp_o,
    output logic                rsp_valid_o
);

    // registered controls from decode
    ctr_pkg::ctr_ctrl_t ctrl;
    // counter state from execute
    logic [ctr_pkg::NUM_CTR-1:0][ctr_pkg::CTR_WIDTH-1:0] values;
    logic [ctr_pkg::NUM_CTR-1:0]                         overflows;

    // decode stage
    ctr_cmd_decoder i_ctr_cmd_decoder (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .ctrl_o      (ctrl)
    );

    // execute stage
    ctr_bank i_ctr_bank (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctrl_i      (ctrl),
        .values_o    (values),
        .overflows_o (overflows)
    );

    // result stage, two cycles from command to response
    ctr_readback i_ctr_readback (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctrl_i      (ctrl),
        .values_i    (values),
        .overflows_i (overflows),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    // full clock period in ns
    parameter int unsigned PERIOD_NS = 8
) (
    output logic clk_o
);

    // free-running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_ctr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ctr_unit;

    // cycles allowed for outstanding responses to drain
    localparam int unsigned RSP_TIMEOUT  = 20;
    localparam int unsigned RESET_CYCLES = 16;

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    ctr_pkg::ctr_cmd_t cmd;
    ctr_pkg::ctr_rsp_t rsp;
    logic              rsp_valid;

    // reference model with one value and one sticky flag per counter
    logic [ctr_pkg::CTR_WIDTH-1:0] model_val [ctr_pkg::NUM_CTR];
    logic                          model_ovf [ctr_pkg::NUM_CTR];

    // expected responses in read order and the cycle each is due
    ctr_pkg::ctr_rsp_t exp_q [$];
    int unsigned       due_q [$];
    ctr_pkg::ctr_rsp_t exp_rsp;
    int unsigned       exp_due;

    int unsigned cycle_cnt = 0;
    integer      seed;
    string       test_name;

    tb_clock_gen #(.PERIOD_NS(8)) i_tb_clock_gen (.clk_o(clk));

    ctr_unit i_ctr_unit (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [ctr_pkg::CTR_WIDTH-1:0] rand_word();
        return ctr_pkg::CTR_WIDTH'($random(seed));
    endfunction

    // drive one command after the edge and advance the model
    task automatic send_cmd(input ctr_pkg::ctr_op_e op,
                            input logic [ctr_pkg::IDX_WIDTH-1:0] idx,
                            input logic [ctr_pkg::CTR_WIDTH-1:0] data);
        logic [ctr_pkg::CTR_WIDTH:0] sum;
        logic [ctr_pkg::CTR_WIDTH:0] diff;
        ctr_pkg::ctr_rsp_t           rsp_exp;
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.idx   = idx;
        cmd.data  = data;
        case (op)
            ctr_pkg::OP_CLEAR: begin
                model_val[idx] = '0;
                model_ovf[idx] = 1'b0;
            end
            ctr_pkg::OP_LOAD: begin
                model_val[idx] = data;
                model_ovf[idx] = 1'b0;
            end
            ctr_pkg::OP_ADD: begin
                sum = {1'b0, model_val[idx]} + {1'b0, data};
                // carry out means the count went past the maximum
                if (sum[ctr_pkg::CTR_WIDTH]) begin
                    model_ovf[idx] = 1'b1;
                end
                model_val[idx] = sum[ctr_pkg::CTR_WIDTH-1:0];
            end
            ctr_pkg::OP_SUB: begin
                diff = {1'b0, model_val[idx]} - {1'b0, data};
                // borrow out means the count went below zero
                if (diff[ctr_pkg::CTR_WIDTH]) begin
                    model_ovf[idx] = 1'b1;
                end
                model_val[idx] = diff[ctr_pkg::CTR_WIDTH-1:0];
            end
            ctr_pkg::OP_READ: begin
                rsp_exp.value    = model_val[idx];
                rsp_exp.overflow = model_ovf[idx];
                exp_q.push_back(rsp_exp);
                // fixed two-cycle read latency
                due_q.push_back(cycle_cnt + 2);
            end
            default: begin
            end
        endcase
    endtask

    // strobe low for one cycle
    task automatic send_idle();
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        // live command fields that the DUT has to ignore
        cmd.op    = ctr_pkg::ctr_op_e'(3'(unsigned'($random(seed)) % 6));
        cmd.idx   = ctr_pkg::IDX_WIDTH'($random(seed));
        cmd.data  = rand_word();
    endtask

    task automatic wait_responses();
        int unsigned waited;
        send_idle();
        waited = 0;
        while (exp_q.size() != 0 && waited < RSP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s: %0d responses missing after %0d cycles",
                     test_name, exp_q.size(), waited);
            $display("Test FAILED");
            $fatal(1, "response timeout");
        end
    endtask

    // response checker samples away from the rising edge
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Response in %s arrived with no read outstanding", test_name);
                $display("Test FAILED");
                $fatal(1, "unexpected response");
            end
            exp_rsp = exp_q.pop_front();
            exp_due = due_q.pop_front();
            assert (rsp == exp_rsp) else begin
                $display("Error %s: expected value %h ovf %b, actual value %h ovf %b",
                         test_name, exp_rsp.value, exp_rsp.overflow,
                         rsp.value, rsp.overflow);
                $display("Test FAILED");
                $fatal(1, "response mismatch");
            end
            assert (cycle_cnt == exp_due) else begin
                $display("Error %s: expected response in cycle %0d, actual cycle %0d",
                         test_name, exp_due, cycle_cnt);
                $display("Test FAILED");
                $fatal(1, "read latency mismatch");
            end
        end
    end

    initial begin
        int unsigned             i;
        int unsigned             r;
        logic [ctr_pkg::IDX_WIDTH-1:0] idx;
        logic [ctr_pkg::CTR_WIDTH-1:0] delta;
        seed      = 62;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        test_name = "reset";
        for (i = 0; i < ctr_pkg::NUM_CTR; i++) begin
            model_val[i] = '0;
            model_ovf[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!rsp_valid && rsp == '0) else begin
            $display("Response outputs not idle after reset");
            $display("Test FAILED");
            $fatal(1, "bad reset state");
        end

        // all counters read back zero two cycles after each read
        test_name = "reset_state";
        for (i = 0; i < ctr_pkg::NUM_CTR; i++) begin
            send_cmd(ctr_pkg::OP_READ, ctr_pkg::IDX_WIDTH'(i), '0);
        end
        wait_responses();

        // each counter keeps its own loaded value
        test_name = "load_readback";
        repeat (2) begin
            for (i = 0; i < ctr_pkg::NUM_CTR; i++) begin
                send_cmd(ctr_pkg::OP_LOAD, ctr_pkg::IDX_WIDTH'(i), rand_word());
            end
            for (i = ctr_pkg::NUM_CTR; i > 0; i--) begin
                send_cmd(ctr_pkg::OP_READ, ctr_pkg::IDX_WIDTH'(i - 1), '0);
            end
        end
        wait_responses();

        // modular add and subtract with deltas of mixed size
        test_name = "add_sub";
        repeat (32) begin
            idx   = ctr_pkg::IDX_WIDTH'($random(seed));
            delta = rand_word() >> (unsigned'($random(seed)) % 16);
            r     = unsigned'($random(seed)) % 2;
            send_cmd((r == 0) ? ctr_pkg::OP_ADD : ctr_pkg::OP_SUB, idx, delta);
            send_cmd(ctr_pkg::OP_READ, idx, '0);
        end
        wait_responses();

        // add up to the maximum and then past it so the flag stays until load
        test_name = "overflow";
        send_cmd(ctr_pkg::OP_CLEAR, 2'd0, '0);
        send_cmd(ctr_pkg::OP_LOAD, 2'd0, 16'hfff0);
        send_cmd(ctr_pkg::OP_ADD, 2'd0, 16'h000f);
        send_cmd(ctr_pkg::OP_READ, 2'd0, '0);
        send_cmd(ctr_pkg::OP_ADD, 2'd0, 16'h0001);
        send_cmd(ctr_pkg::OP_READ, 2'd0, '0);
        send_cmd(ctr_pkg::OP_ADD, 2'd0, 16'h0005);
        send_cmd(ctr_pkg::OP_READ, 2'd0, '0);
        send_cmd(ctr_pkg::OP_LOAD, 2'd0, 16'h1234);
        send_cmd(ctr_pkg::OP_READ, 2'd0, '0);
        // subtract to zero and then below it so the flag stays until clear
        send_cmd(ctr_pkg::OP_LOAD, 2'd1, 16'h0003);
        send_cmd(ctr_pkg::OP_SUB, 2'd1, 16'h0003);
        send_cmd(ctr_pkg::OP_READ, 2'd1, '0);
        send_cmd(ctr_pkg::OP_SUB, 2'd1, 16'h0001);
        send_cmd(ctr_pkg::OP_READ, 2'd1, '0);
        send_cmd(ctr_pkg::OP_ADD, 2'd1, 16'h0002);
        send_cmd(ctr_pkg::OP_READ, 2'd1, '0);
        send_cmd(ctr_pkg::OP_CLEAR, 2'd1, '0);
        send_cmd(ctr_pkg::OP_READ, 2'd1, '0);
        wait_responses();

        // read right behind an update sees the update
        test_name = "add_then_read";
        send_cmd(ctr_pkg::OP_LOAD, 2'd2, 16'd100);
        send_cmd(ctr_pkg::OP_ADD, 2'd2, 16'd7);
        send_cmd(ctr_pkg::OP_READ, 2'd2, '0);
        send_cmd(ctr_pkg::OP_SUB, 2'd2, 16'd50);
        send_cmd(ctr_pkg::OP_READ, 2'd2, '0);
        send_cmd(ctr_pkg::OP_READ, 2'd2, '0);
        wait_responses();

        // mixed stream incl nops, idle cycles and extra reads
        test_name = "random_stream";
        repeat (300) begin
            r     = unsigned'($random(seed)) % 8;
            idx   = ctr_pkg::IDX_WIDTH'($random(seed));
            delta = rand_word();
            case (r)
                6: send_idle();
                7: send_cmd(ctr_pkg::OP_READ, idx, delta);
                default: send_cmd(ctr_pkg::ctr_op_e'(r[2:0]), idx, delta);
            endcase
        end
        wait_responses();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/ctr_pkg.sv
src/delta_counter.sv
src/ctr_cmd_decoder.sv
src/ctr_bank.sv
src/ctr_readback.sv
src/ctr_unit.sv
test/tb_clock_gen.sv
test/tb_ctr_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ctr_unit
FILELIST  := files.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)
